//--- src/lb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared constants for the local register bus. Block number is the upper
// address field, and blocks at or above lb_num_children are unmapped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package lb_pkg;

  // Bus geometry
  localparam int lb_data_w      = 32;
  localparam int lb_addr_w      = 12;
  localparam int lb_chld_addr_w = 8;
  localparam int lb_blk_w       = lb_addr_w - lb_chld_addr_w;

  // Block map, child index equals block number
  localparam int lb_num_children = 2;
  localparam int lb_blk_scratch  = 0;
  localparam int lb_blk_timer    = 1;

  // Returned for reads that hit no child
  localparam logic [lb_data_w-1:0] lb_default_rdata = 32'hdeadbabe;

  // Scratch bank, aliases every scratch_num_regs words
  localparam int scratch_num_regs = 8;
  localparam int scratch_idx_w    = $clog2(scratch_num_regs);

  // Timer register offsets
  localparam logic [lb_chld_addr_w-1:0] tmr_reg_count   = 8'h00;
  localparam logic [lb_chld_addr_w-1:0] tmr_reg_compare = 8'h01;
  localparam logic [lb_chld_addr_w-1:0] tmr_reg_status  = 8'h02;
  localparam logic [lb_chld_addr_w-1:0] tmr_reg_control = 8'h03;

  // Host bridge FSM encoding
  localparam logic [1:0] br_st_idle = 2'd0;
  localparam logic [1:0] br_st_wait = 2'd1;
  localparam logic [1:0] br_st_hold = 2'd2;

endpackage

`default_nettype wire

//--- src/lb_host_bridge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One transaction in flight. Request fields are sampled at acceptance only;
// lb_addr and lb_wr_data stay stable until the next acceptance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module lb_host_bridge
  import lb_pkg::*;
(
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  req_valid,
  output logic                 req_ready,
  input  wire                  req_write,
  input  wire  [lb_addr_w-1:0] req_addr,
  input  wire  [lb_data_w-1:0] req_wdata,
  output logic                 rsp_valid,
  input  wire                  rsp_ready,
  output logic [lb_data_w-1:0] rsp_rdata,
  output logic                 lb_wr_en,
  output logic                 lb_rd_en,
  output logic [lb_addr_w-1:0] lb_addr,
  output logic [lb_data_w-1:0] lb_wr_data,
  input  wire                  lb_wr_valid,
  input  wire                  lb_rd_valid,
  input  wire  [lb_data_w-1:0] lb_rd_data
);

  logic [1:0] state;
  logic       accept;
  logic       lb_done;

  assign accept  = req_valid & req_ready;
  assign lb_done = lb_wr_valid | lb_rd_valid;

  // Response is pending exactly while holding
  assign rsp_valid = (state == br_st_hold);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= br_st_idle;
      req_ready <= 1'b0;
      lb_wr_en  <= 1'b0;
      lb_rd_en  <= 1'b0;
    end
    else
    begin
      // Strobes are single-cycle pulses
      lb_wr_en <= accept & req_write;
      lb_rd_en <= accept & ~req_write;
      case (state)
        br_st_idle:
        begin
          req_ready <= ~accept;
          if (accept)
            state <= br_st_wait;
        end
        br_st_wait:
        begin
          if (lb_done)
            state <= br_st_hold;
        end
        br_st_hold:
        begin
          // Back-pressure point, ready returns with the handshake
          if (rsp_ready)
          begin
            state     <= br_st_idle;
            req_ready <= 1'b1;
          end
        end
        default:
        begin
          state     <= br_st_idle;
          req_ready <= 1'b0;
        end
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      lb_addr    <= req_addr;
      lb_wr_data <= req_wdata;
    end
    // Write completions return zero data
    if (state == br_st_wait && lb_done)
      rsp_rdata <= lb_rd_valid ? lb_rd_data : '0;
  end

  a_strobe_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(lb_wr_en && lb_rd_en));

  // Completion must match an issued strobe
  a_valid_in_wait : assert property (@(posedge clk) disable iff (!rst_n)
    lb_done |-> (state == br_st_wait));

endmodule

`default_nettype wire

//--- src/lb_splitter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expects one outstanding access. Unmapped blocks complete one cycle after
// the strobe with lb_default_rdata, in either register_outputs mode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module lb_splitter
  import lb_pkg::*;
#(
  parameter bit register_outputs = 1'b1
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       lb_wr_en,
  input  wire                       lb_rd_en,
  input  wire  [lb_addr_w-1:0]      lb_addr,
  input  wire  [lb_data_w-1:0]      lb_wr_data,
  output logic                      lb_wr_valid,
  output logic                      lb_rd_valid,
  output logic [lb_data_w-1:0]      lb_rd_data,
  output logic [lb_num_children-1:0] chld_wr_en,
  output logic [lb_num_children-1:0] chld_rd_en,
  output logic [lb_chld_addr_w-1:0] chld_addr    [lb_num_children],
  output logic [lb_data_w-1:0]      chld_wr_data [lb_num_children],
  input  wire  [lb_num_children-1:0] chld_wr_valid,
  input  wire  [lb_num_children-1:0] chld_rd_valid,
  input  wire  [lb_data_w-1:0]      chld_rd_data [lb_num_children]
);

  logic [lb_blk_w-1:0]        blk;
  logic [lb_blk_w-1:0]        blk_q;
  logic [lb_chld_addr_w-1:0]  child_addr;
  logic [lb_num_children-1:0] strb_sel;
  logic [lb_num_children-1:0] rsp_sel;
  logic [lb_data_w-1:0]       gated_rd_data [lb_num_children];
  logic [lb_data_w-1:0]       merged_rd_data;
  logic                       merged_wr_valid;
  logic                       merged_rd_valid;
  logic                       unm_wr;
  logic                       unm_rd;

  assign {blk, child_addr} = lb_addr;

  // Strobe routing from live address, response gating from latched block
  for (genvar i = 0; i < lb_num_children; i++)
  begin : g_sel
    assign strb_sel[i]      = (blk == lb_blk_w'(i));
    assign rsp_sel[i]       = (blk_q == lb_blk_w'(i));
    assign gated_rd_data[i] = chld_rd_data[i] & {lb_data_w{rsp_sel[i]}};
  end

  assign unm_wr          = lb_wr_en & ~(|strb_sel);
  assign unm_rd          = lb_rd_en & ~(|strb_sel);
  assign merged_wr_valid = |(chld_wr_valid & rsp_sel);
  assign merged_rd_valid = |(chld_rd_valid & rsp_sel);

  always_comb
  begin
    merged_rd_data = '0;
    for (int i = 0; i < lb_num_children; i++)
      merged_rd_data = merged_rd_data | gated_rd_data[i];
  end

  // Block of the access in flight
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      blk_q <= '0;
    else if (lb_wr_en || lb_rd_en)
      blk_q <= blk;
  end

  if (register_outputs)
  begin : g_reg
    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        lb_wr_valid <= 1'b0;
        lb_rd_valid <= 1'b0;
        chld_wr_en  <= '0;
        chld_rd_en  <= '0;
      end
      else
      begin
        lb_wr_valid <= unm_wr | merged_wr_valid;
        lb_rd_valid <= unm_rd | merged_rd_valid;
        chld_wr_en  <= strb_sel & {lb_num_children{lb_wr_en}};
        chld_rd_en  <= strb_sel & {lb_num_children{lb_rd_en}};
      end
    end

    always_ff @(posedge clk)
    begin
      lb_rd_data <= unm_rd ? lb_default_rdata : merged_rd_data;
      for (int i = 0; i < lb_num_children; i++)
      begin
        chld_addr[i]    <= child_addr;
        chld_wr_data[i] <= lb_wr_data;
      end
    end
  end
  else
  begin : g_comb
    logic unm_wr_q;
    logic unm_rd_q;

    // Own completion still takes one cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        unm_wr_q <= 1'b0;
        unm_rd_q <= 1'b0;
      end
      else
      begin
        unm_wr_q <= unm_wr;
        unm_rd_q <= unm_rd;
      end
    end

    assign lb_wr_valid = unm_wr_q | merged_wr_valid;
    assign lb_rd_valid = unm_rd_q | merged_rd_valid;
    assign lb_rd_data  = unm_rd_q ? lb_default_rdata : merged_rd_data;
    assign chld_wr_en  = strb_sel & {lb_num_children{lb_wr_en}};
    assign chld_rd_en  = strb_sel & {lb_num_children{lb_rd_en}};

    always_comb
    begin
      for (int i = 0; i < lb_num_children; i++)
      begin
        chld_addr[i]    = child_addr;
        chld_wr_data[i] = lb_wr_data;
      end
    end
  end

  // Only the addressed child may ever answer
  a_one_child : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(chld_wr_valid | chld_rd_valid));

endmodule

`default_nettype wire

//--- src/lb_scratch_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Only the low scratch_idx_w address bits decode, so registers alias
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module lb_scratch_regs
  import lb_pkg::*;
(
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       wr_en,
  input  wire                       rd_en,
  input  wire  [lb_chld_addr_w-1:0] addr,
  input  wire  [lb_data_w-1:0]      wr_data,
  output logic                      wr_valid,
  output logic                      rd_valid,
  output logic [lb_data_w-1:0]      rd_data
);

  logic [lb_data_w-1:0]     regs [scratch_num_regs];
  logic [scratch_idx_w-1:0] idx;

  assign idx = addr[scratch_idx_w-1:0];

  // Bank clears to zero
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < scratch_num_regs; i++)
        regs[i] <= '0;
    end
    else if (wr_en)
    begin
      regs[idx] <= wr_data;
    end
  end

  // One-cycle completion for both directions
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_valid <= 1'b0;
      rd_valid <= 1'b0;
      rd_data  <= '0;
    end
    else
    begin
      wr_valid <= wr_en;
      rd_valid <= rd_en;
      // Zero when idle, so the splitter can OR
      rd_data  <= rd_en ? regs[idx] : '0;
    end
  end

endmodule

`default_nettype wire

//--- src/lb_timer_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reads sample the register two cycles after the strobe. Match sets only
// while enabled; a status write of 1 in bit 0 clears it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module lb_timer_regs
  import lb_pkg::*;
(
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       wr_en,
  input  wire                       rd_en,
  input  wire  [lb_chld_addr_w-1:0] addr,
  input  wire  [lb_data_w-1:0]      wr_data,
  output logic                      wr_valid,
  output logic                      rd_valid,
  output logic [lb_data_w-1:0]      rd_data,
  output logic                      timer_match
);

  logic [lb_data_w-1:0]      count;
  logic [lb_data_w-1:0]      compare;
  logic                      enable;
  logic                      rd_pend_q;
  logic [lb_chld_addr_w-1:0] rd_addr_q;
  logic [lb_data_w-1:0]      rd_mux;

  // Register state and write decode
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count       <= '0;
      compare     <= '0;
      enable      <= 1'b0;
      timer_match <= 1'b0;
      wr_valid    <= 1'b0;
    end
    else
    begin
      wr_valid <= wr_en;
      if (wr_en && addr == tmr_reg_count)
        count <= wr_data;
      else if (enable)
        count <= count + 1'b1;
      if (wr_en && addr == tmr_reg_compare)
        compare <= wr_data;
      if (wr_en && addr == tmr_reg_control)
        enable <= wr_data[0];
      // Clear by write takes priority over a new match
      if (wr_en && addr == tmr_reg_status && wr_data[0])
        timer_match <= 1'b0;
      else if (enable && count == compare)
        timer_match <= 1'b1;
    end
  end

  // Stage one, latch which register is read
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rd_pend_q <= 1'b0;
    else
      rd_pend_q <= rd_en;
  end

  always_ff @(posedge clk)
  begin
    if (rd_en)
      rd_addr_q <= addr;
  end

  always_comb
  begin
    case (rd_addr_q)
      tmr_reg_count:   rd_mux = count;
      tmr_reg_compare: rd_mux = compare;
      tmr_reg_status:  rd_mux = {{(lb_data_w-1){1'b0}}, timer_match};
      tmr_reg_control: rd_mux = {{(lb_data_w-1){1'b0}}, enable};
      default:         rd_mux = '0;
    endcase
  end

  // Stage two, output register
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_valid <= 1'b0;
      rd_data  <= '0;
    end
    else
    begin
      rd_valid <= rd_pend_q;
      rd_data  <= rd_pend_q ? rd_mux : '0;
    end
  end

  a_rd_latency : assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid |-> $past(rd_en, 2));

endmodule

`default_nettype wire

//--- src/lb_subsys.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Block 0 is the scratch bank, block 1 the timer, the rest unmapped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module lb_subsys
  import lb_pkg::*;
(
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  req_valid,
  output logic                 req_ready,
  input  wire                  req_write,
  input  wire  [lb_addr_w-1:0] req_addr,
  input  wire  [lb_data_w-1:0] req_wdata,
  output logic                 rsp_valid,
  input  wire                  rsp_ready,
  output logic [lb_data_w-1:0] rsp_rdata,
  output logic                 timer_match
);

  // Local bus
  logic                 lb_wr_en;
  logic                 lb_rd_en;
  logic [lb_addr_w-1:0] lb_addr;
  logic [lb_data_w-1:0] lb_wr_data;
  logic                 lb_wr_valid;
  logic                 lb_rd_valid;
  logic [lb_data_w-1:0] lb_rd_data;

  // Child bus, indexed by block number
  logic [lb_num_children-1:0] chld_wr_en;
  logic [lb_num_children-1:0] chld_rd_en;
  logic [lb_chld_addr_w-1:0]  chld_addr     [lb_num_children];
  logic [lb_data_w-1:0]       chld_wr_data  [lb_num_children];
  logic [lb_num_children-1:0] chld_wr_valid;
  logic [lb_num_children-1:0] chld_rd_valid;
  logic [lb_data_w-1:0]       chld_rd_data  [lb_num_children];

  lb_host_bridge lb_host_bridge_i (
    .clk, .rst_n,
    .req_valid, .req_ready, .req_write, .req_addr, .req_wdata,
    .rsp_valid, .rsp_ready, .rsp_rdata,
    .lb_wr_en, .lb_rd_en, .lb_addr, .lb_wr_data,
    .lb_wr_valid, .lb_rd_valid, .lb_rd_data
  );

  lb_splitter #(
    .register_outputs (1'b1)
  ) lb_splitter_i (
    .clk, .rst_n,
    .lb_wr_en, .lb_rd_en, .lb_addr, .lb_wr_data,
    .lb_wr_valid, .lb_rd_valid, .lb_rd_data,
    .chld_wr_en, .chld_rd_en, .chld_addr, .chld_wr_data,
    .chld_wr_valid, .chld_rd_valid, .chld_rd_data
  );

  lb_scratch_regs lb_scratch_regs_i (
    .clk, .rst_n,
    .wr_en    (chld_wr_en[lb_blk_scratch]),
    .rd_en    (chld_rd_en[lb_blk_scratch]),
    .addr     (chld_addr[lb_blk_scratch]),
    .wr_data  (chld_wr_data[lb_blk_scratch]),
    .wr_valid (chld_wr_valid[lb_blk_scratch]),
    .rd_valid (chld_rd_valid[lb_blk_scratch]),
    .rd_data  (chld_rd_data[lb_blk_scratch])
  );

  lb_timer_regs lb_timer_regs_i (
    .clk, .rst_n,
    .wr_en       (chld_wr_en[lb_blk_timer]),
    .rd_en       (chld_rd_en[lb_blk_timer]),
    .addr        (chld_addr[lb_blk_timer]),
    .wr_data     (chld_wr_data[lb_blk_timer]),
    .wr_valid    (chld_wr_valid[lb_blk_timer]),
    .rd_valid    (chld_rd_valid[lb_blk_timer]),
    .rd_data     (chld_rd_data[lb_blk_timer]),
    .timer_match
  );

endmodule

`default_nettype wire

//--- test/lb_subsys_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One request at a time from the host side. Inputs change on the falling
// edge, outputs sampled there too. Stops at the first failed check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module lb_subsys_tb
  import lb_pkg::*;
();

  localparam int half_period  = 50;
  localparam int reset_cycles = 16;
  localparam int txn_budget   = 200;
  localparam logic [lb_blk_w-1:0] blk_scratch_sel = lb_blk_w'(lb_blk_scratch);
  localparam logic [lb_blk_w-1:0] blk_timer_sel   = lb_blk_w'(lb_blk_timer);

  logic                 clk;
  logic                 rst_n;
  logic                 req_valid;
  logic                 req_ready;
  logic                 req_write;
  logic [lb_addr_w-1:0] req_addr;
  logic [lb_data_w-1:0] req_wdata;
  logic                 rsp_valid;
  logic                 rsp_ready;
  logic [lb_data_w-1:0] rsp_rdata;
  logic                 timer_match;

  integer               seed;
  int                   issued;
  int                   acc_cnt;
  int                   rsp_cnt;
  // Reference copy of the scratch bank
  logic [lb_data_w-1:0] scratch_model [scratch_num_regs];

  lb_subsys lb_subsys_i (
    .clk, .rst_n,
    .req_valid, .req_ready, .req_write, .req_addr, .req_wdata,
    .rsp_valid, .rsp_ready, .rsp_rdata,
    .timer_match
  );

  initial
  begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // Acceptances against completed responses
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      acc_cnt <= 0;
      rsp_cnt <= 0;
    end
    else
    begin
      if (req_valid && req_ready)
        acc_cnt <= acc_cnt + 1;
      if (rsp_valid && rsp_ready)
        rsp_cnt <= rsp_cnt + 1;
    end
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [lb_data_w-1:0] expected,
                             input logic [lb_data_w-1:0] actual);
    assert (actual === expected)
    else
    begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      report_failure("data check failed");
    end
  endtask

  task automatic check_increasing(input string name, input logic [lb_data_w-1:0] earlier,
                                  input logic [lb_data_w-1:0] later);
    assert (later > earlier)
    else
    begin
      $display("error %s: expected above %h, actual %h", name, earlier, later);
      report_failure("counter did not advance");
    end
  endtask

  // Held response must not move, and the host side stays blocked
  a_rsp_hold : assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
    else report_failure("response dropped or changed while rsp_ready was low");

  a_busy_ready : assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> !req_ready)
    else report_failure("req_ready was high while a response was pending");

  // Exactly one response per accepted request
  a_one_rsp : assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> acc_cnt == rsp_cnt + 1)
    else report_failure("response pending with no request outstanding");

  function automatic logic [lb_addr_w-1:0] make_addr(input logic [lb_blk_w-1:0] blk,
                                                      input logic [lb_chld_addr_w-1:0] off);
    return {blk, off};
  endfunction

  // Random upper offset bits over a fixed register index
  function automatic logic [lb_chld_addr_w-1:0] alias_offset(input int idx);
    logic [lb_chld_addr_w-1:0] upper;
    upper = lb_chld_addr_w'($random(seed));
    return (upper & ~lb_chld_addr_w'(scratch_num_regs - 1)) | lb_chld_addr_w'(idx);
  endfunction

  task automatic run_access(input logic write, input logic [lb_addr_w-1:0] addr,
                            input logic [lb_data_w-1:0] wdata,
                            output logic [lb_data_w-1:0] rdata);
    logic done;
    issued++;
    @(negedge clk);
    req_valid = 1'b1;
    req_write = write;
    req_addr  = addr;
    req_wdata = wdata;
    while (!req_ready)
      @(negedge clk);
    @(negedge clk);
    req_valid = 1'b0;
    // Randomly withheld rsp_ready until the handshake
    done = 1'b0;
    while (!done)
    begin
      rsp_ready = 1'($random(seed));
      rdata     = rsp_rdata;
      done      = rsp_valid && rsp_ready;
      @(negedge clk);
    end
    rsp_ready = 1'b0;
  endtask

  task automatic bus_write(input string name, input logic [lb_addr_w-1:0] addr,
                           input logic [lb_data_w-1:0] data);
    logic [lb_data_w-1:0] rdata;
    run_access(1'b1, addr, data, rdata);
    check_value({name, " write response"}, '0, rdata);
  endtask

  task automatic bus_read(input logic [lb_addr_w-1:0] addr,
                          output logic [lb_data_w-1:0] data);
    run_access(1'b0, addr, '0, data);
  endtask

  task automatic read_expect(input string name, input logic [lb_addr_w-1:0] addr,
                             input logic [lb_data_w-1:0] expected);
    logic [lb_data_w-1:0] data;
    bus_read(addr, data);
    check_value(name, expected, data);
  endtask

  task automatic verify_scratch(input string name);
    for (int i = 0; i < scratch_num_regs; i++)
      read_expect(name, make_addr(blk_scratch_sel, alias_offset(i)), scratch_model[i]);
  endtask

  // Budget grows with every issued transaction
  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= reset_cycles + txn_budget * (issued + 1))
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: no progress after %0d cycles, %0d transactions issued",
             cycles, issued);
    report_failure("simulation stopped by the watchdog");
  end

  initial
  begin : stimulus
    int                        order [scratch_num_regs];
    int                        j;
    int                        tmp;
    int                        untouched;
    logic [lb_data_w-1:0]      data;
    logic [lb_data_w-1:0]      first;
    logic [lb_blk_w-1:0]       blk;

    seed      = 32'hfa1e;
    issued    = 0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    rsp_ready = 1'b0;
    for (int i = 0; i < scratch_num_regs; i++)
      scratch_model[i] = '0;
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;

    // Scratch register still at its reset value
    untouched = $unsigned($random(seed)) % scratch_num_regs;
    read_expect("scratch reset value", make_addr(blk_scratch_sel, alias_offset(untouched)), '0);
    for (int i = 0; i < scratch_num_regs; i++)
      order[i] = i;
    for (int i = scratch_num_regs - 1; i > 0; i--)
    begin
      j        = $unsigned($random(seed)) % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < scratch_num_regs; i++)
    begin
      data                    = $random(seed);
      scratch_model[order[i]] = data;
      bus_write("scratch", make_addr(blk_scratch_sel, alias_offset(order[i])), data);
    end
    verify_scratch("scratch readback");

    // Unmapped blocks answer from the splitter
    blk = lb_blk_w'(lb_num_children + $unsigned($random(seed)) % (16 - lb_num_children));
    bus_read(make_addr(blk, lb_chld_addr_w'($random(seed))), data);
    check_value("unmapped read", lb_default_rdata, data);
    blk = lb_blk_w'(lb_num_children + $unsigned($random(seed)) % (16 - lb_num_children));
    bus_write("unmapped", make_addr(blk, lb_chld_addr_w'($random(seed))), $random(seed));
    verify_scratch("scratch after unmapped write");

    // Timer load and compare while disabled
    bus_write("timer control", make_addr(blk_timer_sel, tmr_reg_control), 32'd0);
    bus_write("timer count", make_addr(blk_timer_sel, tmr_reg_count), 32'd10);
    bus_write("timer compare", make_addr(blk_timer_sel, tmr_reg_compare), 32'd40);
    read_expect("timer count load", make_addr(blk_timer_sel, tmr_reg_count), 32'd10);
    read_expect("timer compare load", make_addr(blk_timer_sel, tmr_reg_compare), 32'd40);
    bus_write("timer enable", make_addr(blk_timer_sel, tmr_reg_control), 32'd1);
    repeat (70) @(negedge clk);
    bus_write("timer disable", make_addr(blk_timer_sel, tmr_reg_control), 32'd0);
    check_value("timer_match set", 32'd1, 32'(timer_match));
    read_expect("timer status set", make_addr(blk_timer_sel, tmr_reg_status), 32'd1);
    bus_write("timer status clear", make_addr(blk_timer_sel, tmr_reg_status), 32'd1);
    check_value("timer_match cleared", 32'd0, 32'(timer_match));
    read_expect("timer status cleared", make_addr(blk_timer_sel, tmr_reg_status), 32'd0);

    // Counting only while enabled
    bus_write("timer enable", make_addr(blk_timer_sel, tmr_reg_control), 32'd1);
    bus_read(make_addr(blk_timer_sel, tmr_reg_count), first);
    bus_read(make_addr(blk_timer_sel, tmr_reg_count), data);
    check_increasing("timer running", first, data);
    bus_write("timer disable", make_addr(blk_timer_sel, tmr_reg_control), 32'd0);
    bus_read(make_addr(blk_timer_sel, tmr_reg_count), first);
    bus_read(make_addr(blk_timer_sel, tmr_reg_count), data);
    check_value("timer stopped", first, data);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- lb_subsys.f
src/lb_pkg.sv
src/lb_host_bridge.sv
src/lb_splitter.sv
src/lb_scratch_regs.sv
src/lb_timer_regs.sv
src/lb_subsys.sv
test/lb_subsys_tb.sv

//--- build.sh
#!/bin/sh
# Compile and run the lb_subsys testbench with Verilator.
# Pass or fail is read from the simulation log.

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module lb_subsys_tb -Mdir obj_dir -f lb_subsys.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/Vlb_subsys_tb > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "RESULT: FAIL" "$log_file"; then
  echo "simulation reported a failure, see $log_file"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

echo "simulation finished cleanly"
exit 0
